// ==== Bender.yml ====
package:
  name: uart_frame

sources:
  - hw/uart_frame_pkg.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/frame_tx.sv
  - hw/frame_rx.sv
  - hw/uart_frame_top.sv
  - target: simulation
    files:
      - dv/uart_frame_tb.sv

// ==== dv/uart_frame_tb.sv ====
// testbench for uart_frame_top, vectors in dv/uart_frame_testdata.txt
// run from the project root so the vector path resolves
// stops at the first mismatch, whole run bounded by a cycle counter
`timescale 1ns/10ps
`default_nettype none

module uart_frame_tb;

	localparam int CHAR_CLKS = 10 * uart_frame_pkg::CLKS_PER_BIT;

	logic                       sys_clk;
	logic                       sys_rst_n;
	uart_frame_pkg::frame_str_t tx_string;
	uart_frame_pkg::frame_len_t tx_length;
	logic                       tx_req;
	logic                       tx_busy;
	logic                       tx_done;
	uart_frame_pkg::frame_str_t rx_string;
	uart_frame_pkg::frame_len_t rx_length;
	logic                       rx_busy;
	logic                       rx_done;
	logic                       rx_error;
	logic                       uart_rx_port;
	logic                       uart_tx_port;

	// 1 routes the transmitter back into the receiver
	logic                       loop_sel;
	logic                       ser_line;

	logic [7:0]                 tdata [0:255];
	logic [31:0]                lfsr;
	int                         cycles;
	int                         cycle_limit;
	int                         tx_done_cnt;
	int                         rx_done_cnt;
	int                         rx_error_cnt;
	logic                       rx_busy_seen;

	// last frame the receiver should have published
	uart_frame_pkg::frame_str_t last_str;
	uart_frame_pkg::frame_len_t last_len;

	assign uart_rx_port = loop_sel ? uart_tx_port : ser_line;

	uart_frame_top uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial sys_clk = 1'b0;
	always #2 sys_clk = ~sys_clk;

	// strobe counters, sampled mid-cycle
	always @(negedge sys_clk) begin
		if (tx_done === 1'b1) tx_done_cnt = tx_done_cnt + 1;
		if (rx_done === 1'b1) rx_done_cnt = rx_done_cnt + 1;
		if (rx_error === 1'b1) rx_error_cnt = rx_error_cnt + 1;
		if (rx_busy === 1'b1) rx_busy_seen = 1'b1;
	end

	always @(posedge sys_clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: no response from the DUT within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic compare_byte(input string name, input uart_frame_pkg::uart_byte_t act,
			input uart_frame_pkg::uart_byte_t exp);
		if (act !== exp) begin
			$display("** Error: %s = %h, expected %h", name, act, exp);
			stop_run();
		end
	endtask

	task automatic compare_len(input string name, input uart_frame_pkg::frame_len_t act,
			input uart_frame_pkg::frame_len_t exp);
		if (act !== exp) begin
			$display("** Error: %s = %h, expected %h", name, act, exp);
			stop_run();
		end
	endtask

	task automatic compare_str(input string name, input uart_frame_pkg::frame_str_t act,
			input uart_frame_pkg::frame_str_t exp);
		if (act !== exp) begin
			$display("** Error: %s = %h, expected %h", name, act, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		if (got != want) begin
			$display("%s strobed %0d times where %0d were expected", name, got, want);
			stop_run();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		if (cond !== 1'b1) begin
			$display("%s", what);
			stop_run();
		end
	endtask

	// keeps only the first n bytes of a payload
	function automatic uart_frame_pkg::frame_str_t len_mask(input int n);
		uart_frame_pkg::frame_str_t m;
		m = '0;
		for (int i = 0; i < n; i++) m[8*i +: 8] = 8'hff;
		return m;
	endfunction

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_filler(output uart_frame_pkg::uart_byte_t b);
		b = uart_frame_pkg::FRAME_MARK;
		while (b == uart_frame_pkg::FRAME_MARK) begin
			for (int i = 0; i < 8; i++) begin
				lfsr = lfsr_step(lfsr);
				b[i] = lfsr[0];
			end
		end
	endtask

	// one bit time on the serial driver line
	task automatic drive_line(input logic v);
		@(posedge sys_clk);
		#1;
		ser_line = v;
		repeat (uart_frame_pkg::CLKS_PER_BIT - 1) @(posedge sys_clk);
	endtask

	task automatic send_serial_byte(input uart_frame_pkg::uart_byte_t b);
		drive_line(1'b0);
		for (int i = 0; i < 8; i++) drive_line(b[i]);
		drive_line(1'b1);
	endtask

	// decodes one 8N1 character from uart_tx_port at mid-bit
	task automatic receive_byte(output uart_frame_pkg::uart_byte_t b);
		@(negedge sys_clk);
		while (uart_tx_port === 1'b1) @(negedge sys_clk);
		repeat (uart_frame_pkg::CLKS_PER_BIT / 2) @(negedge sys_clk);
		check_true(uart_tx_port === 1'b0, "start bit on uart_tx_port did not last to mid-bit");
		for (int i = 0; i < 8; i++) begin
			repeat (uart_frame_pkg::CLKS_PER_BIT) @(negedge sys_clk);
			b[i] = uart_tx_port;
		end
		repeat (uart_frame_pkg::CLKS_PER_BIT) @(negedge sys_clk);
		check_true(uart_tx_port === 1'b1, "stop bit on uart_tx_port read low");
	endtask

	// outcome of a record against the receive side
	task automatic check_rx(input int p);
		int n;
		int elen;
		uart_frame_pkg::frame_str_t exp_str;
		n = tdata[p+1];
		elen = tdata[p+3+n];
		exp_str = '0;
		for (int i = 0; i < elen; i++) exp_str[8*i +: 8] = tdata[p+4+n+i];
		check_true(rx_busy_seen === 1'b1, "rx_busy never rose while the frame came in");
		if (tdata[p+2+n] == 8'h00) begin
			check_count("rx_done", rx_done_cnt, 1);
			check_count("rx_error", rx_error_cnt, 0);
			last_len = uart_frame_pkg::frame_len_t'(elen);
			last_str = exp_str;
		end else begin
			check_count("rx_done", rx_done_cnt, 0);
			check_count("rx_error", rx_error_cnt, 1);
		end
		compare_len("rx_length", rx_length, last_len);
		compare_str("rx_string", rx_string & len_mask(last_len), last_str);
		check_true(rx_busy === 1'b0, "rx_busy still high after the frame");
	endtask

	task automatic run_loopback(input int p);
		int n;
		uart_frame_pkg::frame_str_t payload;
		uart_frame_pkg::uart_byte_t got;
		uart_frame_pkg::uart_byte_t want;
		n = tdata[p+1];
		payload = '0;
		for (int i = 0; i < n; i++) payload[8*i +: 8] = tdata[p+2+i];
		@(posedge sys_clk);
		#1;
		loop_sel = 1'b1;
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		rx_error_cnt = 0;
		rx_busy_seen = 1'b0;
		tx_string = payload;
		tx_length = uart_frame_pkg::frame_len_t'(n);
		tx_req = 1'b1;
		fork
			begin
				@(posedge sys_clk);
				#1;
				tx_req = 1'b0;
				repeat (4) @(posedge sys_clk);
				#1;
				check_true(tx_busy === 1'b1, "tx_busy low while a frame is being sent");
				// second request during the frame, must be dropped
				tx_length = 5'd3;
				tx_req = 1'b1;
				@(posedge sys_clk);
				#1;
				tx_req = 1'b0;
			end
			begin
				for (int k = 0; k < n + 4; k++) begin
					receive_byte(got);
					if ((k < 2) || (k >= n + 2)) want = uart_frame_pkg::FRAME_MARK;
					else want = payload[8*(k-2) +: 8];
					compare_byte("uart_tx_port", got, want);
				end
			end
		join
		while (tx_done_cnt == 0) @(posedge sys_clk);
		// line must stay idle, no second frame
		repeat (2 * CHAR_CLKS) begin
			@(negedge sys_clk);
			check_true(uart_tx_port === 1'b1, "uart_tx_port active after the frame ended");
		end
		check_count("tx_done", tx_done_cnt, 1);
		check_true(tx_busy === 1'b0, "tx_busy still high after tx_done");
		check_rx(p);
	endtask

	task automatic run_raw(input int p);
		int n;
		uart_frame_pkg::uart_byte_t b;
		n = tdata[p+1];
		@(posedge sys_clk);
		#1;
		loop_sel = 1'b0;
		rx_done_cnt = 0;
		rx_error_cnt = 0;
		rx_busy_seen = 1'b0;
		for (int k = 0; k < 3; k++) begin
			next_filler(b);
			send_serial_byte(b);
		end
		for (int k = 0; k < n; k++) send_serial_byte(tdata[p+2+k]);
		while (rx_done_cnt + rx_error_cnt == 0) @(posedge sys_clk);
		repeat (CHAR_CLKS) @(posedge sys_clk);
		check_rx(p);
	endtask

	initial begin
		int p;
		int n;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		loop_sel = 1'b1;
		ser_line = 1'b1;
		lfsr = 32'h8cfe566c;
		cycles = 0;
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		rx_error_cnt = 0;
		rx_busy_seen = 1'b0;
		last_str = '0;
		last_len = '0;
		$readmemh("dv/uart_frame_testdata.txt", tdata);
		check_true(!$isunknown(tdata[0]), "test vector file could not be read");

		// (count + 4) characters per record, plus idle windows and fillers
		cycle_limit = 200;
		p = 0;
		while ((p < 200) && (tdata[p] !== 8'hff)) begin
			n = tdata[p+1];
			cycle_limit = cycle_limit + (n + 4 + 6) * (CHAR_CLKS + 1);
			p = p + 4 + n + tdata[p+3+n];
		end

		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		compare_len("rx_length", rx_length, '0);
		check_true(uart_tx_port === 1'b1, "uart_tx_port not idle high after reset");
		check_true(tx_busy === 1'b0 && rx_busy === 1'b0, "busy flag high after reset");
		check_true(tx_done === 1'b0 && rx_done === 1'b0 && rx_error === 1'b0,
			"done or error strobe high after reset");

		p = 0;
		while ((p < 200) && (tdata[p] !== 8'hff)) begin
			n = tdata[p+1];
			if (tdata[p] == 8'h00) run_loopback(p);
			else run_raw(p);
			p = p + 4 + n + tdata[p+3+n];
		end

		repeat (4) @(posedge sys_clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/uart_frame_testdata.txt ====
// mode (00 loopback send, 01 raw serial), count, count bytes,
// outcome (00 done, 01 error), expected length, expected payload bytes; ff ends
// loopback "Hello"
00 05 48 65 6c 6c 6f 00 05 48 65 6c 6c 6f
// loopback empty payload
00 00 00 00
// loopback full 16 byte payload
00 10 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50
00 10 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50
// raw lone mark, stray byte, then "&&ok&&"
01 08 26 78 26 26 6f 6b 26 26 00 02 6f 6b
// raw oversize body of 17 bytes
01 13 26 26 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71
01 00
// raw body mark followed by a non-mark
01 06 26 26 61 62 26 7a 01 00
// loopback "uart" after the errors
00 04 75 61 72 74 00 04 75 61 72 74
ff

// ==== hw/frame_rx.sv ====
// frame parser for "&&payload&&"
// rx_string and rx_length change only on a good frame
// host must take rx_done data before the next frame completes
`timescale 1ns/10ps
`default_nettype none

module frame_rx (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::uart_byte_t rx_byte,
	input  logic                       rx_vld,
	output uart_frame_pkg::frame_str_t rx_string,
	output uart_frame_pkg::frame_len_t rx_length,
	output logic                       rx_busy,
	output logic                       rx_done,
	output logic                       rx_error
);

	typedef enum logic [1:0] {
		FRX_HUNT,
		FRX_OPEN2,
		FRX_BODY,
		FRX_CLOSE2
	} frx_state_e;

	frx_state_e                  state;
	uart_frame_pkg::frame_str_t  work_str;
	uart_frame_pkg::frame_len_t  work_len;
	logic                        is_mark;
	logic                        store;
	logic                        publish;

	assign is_mark = (rx_byte == uart_frame_pkg::FRAME_MARK);
	assign rx_busy = (state != FRX_HUNT);

	// payload byte that still fits in the buffer
	assign store = rx_vld && (state == FRX_BODY) && !is_mark &&
		(work_len != uart_frame_pkg::frame_len_t'(uart_frame_pkg::MAX_LEN));

	// second closing mark
	assign publish = rx_vld && (state == FRX_CLOSE2) && is_mark;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= FRX_HUNT;
			work_len  <= '0;
			rx_length <= '0;
			rx_done   <= 1'b0;
			rx_error  <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (rx_vld) begin
				case (state)
					FRX_HUNT: begin
						if (is_mark) begin
							state <= FRX_OPEN2;
						end
					end
					FRX_OPEN2: begin
						// lone mark falls back quietly
						if (is_mark) begin
							state    <= FRX_BODY;
							work_len <= '0;
						end else begin
							state <= FRX_HUNT;
						end
					end
					FRX_BODY: begin
						if (is_mark) begin
							state <= FRX_CLOSE2;
						end else if (store) begin
							work_len <= work_len + 5'd1;
						end else begin
							// 17th payload byte
							state    <= FRX_HUNT;
							rx_error <= 1'b1;
						end
					end
					FRX_CLOSE2: begin
						state <= FRX_HUNT;
						if (is_mark) begin
							rx_length <= work_len;
							rx_done   <= 1'b1;
						end else begin
							rx_error <= 1'b1;
						end
					end
					default: state <= FRX_HUNT;
				endcase
			end
		end
	end

	// working buffer and published copy
	always_ff @(posedge sys_clk) begin
		if (store) begin
			work_str[8*work_len +: 8] <= rx_byte;
		end
		if (publish) begin
			rx_string <= work_str;
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_tx.sv ====
// frame sender: "&&", tx_length payload bytes, "&&"
// tx_req is taken only while tx_busy is low
// tx_length above MAX_LEN is not supported
`timescale 1ns/10ps
`default_nettype none

module frame_tx (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::frame_str_t tx_string,
	input  uart_frame_pkg::frame_len_t tx_length,
	input  logic                       tx_req,
	output logic                       tx_busy,
	output logic                       tx_done,
	output uart_frame_pkg::uart_byte_t byte_data,
	output logic                       byte_req,
	input  logic                       byte_done
);

	typedef enum logic [1:0] {
		FTX_IDLE,
		FTX_OPEN,
		FTX_BODY,
		FTX_CLOSE
	} ftx_state_e;

	ftx_state_e                  state;
	logic                        mark_cnt;
	uart_frame_pkg::frame_len_t  byte_idx;
	uart_frame_pkg::frame_str_t  str_q;
	uart_frame_pkg::frame_len_t  len_q;

	assign tx_busy = (state != FTX_IDLE);

	// payload byte in body, a mark everywhere else
	assign byte_data = (state == FTX_BODY) ? str_q[8*byte_idx +: 8] : uart_frame_pkg::FRAME_MARK;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= FTX_IDLE;
			mark_cnt <= 1'b0;
			byte_idx <= '0;
			byte_req <= 1'b0;
			tx_done  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			tx_done  <= 1'b0;
			case (state)
				FTX_IDLE: begin
					if (tx_req) begin
						state    <= FTX_OPEN;
						mark_cnt <= 1'b0;
						byte_req <= 1'b1;
					end
				end
				FTX_OPEN: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (!mark_cnt) begin
							mark_cnt <= 1'b1;
						end else if (len_q == '0) begin
							// empty payload, straight to closing marks
							state    <= FTX_CLOSE;
							mark_cnt <= 1'b0;
						end else begin
							state    <= FTX_BODY;
							byte_idx <= '0;
						end
					end
				end
				FTX_BODY: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (byte_idx + 5'd1 == len_q) begin
							state    <= FTX_CLOSE;
							mark_cnt <= 1'b0;
						end else begin
							byte_idx <= byte_idx + 5'd1;
						end
					end
				end
				FTX_CLOSE: begin
					if (byte_done) begin
						if (!mark_cnt) begin
							mark_cnt <= 1'b1;
							byte_req <= 1'b1;
						end else begin
							state   <= FTX_IDLE;
							tx_done <= 1'b1;
						end
					end
				end
				default: state <= FTX_IDLE;
			endcase
		end
	end

	// host data captured on an accepted request
	always_ff @(posedge sys_clk) begin
		if ((state == FTX_IDLE) && tx_req) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_frame_pkg.sv ====
// shared constants and vector types for the UART framing link
// bit time is fixed at build time, there is no runtime baud setting
// payloads are at most MAX_LEN bytes and must not contain FRAME_MARK
`default_nettype none

package uart_frame_pkg;

	// sys_clk cycles per UART bit, small to keep simulation short
	localparam int CLKS_PER_BIT = 8;

	// largest payload in bytes
	localparam int MAX_LEN = 16;

	// one character on the line
	typedef logic [7:0] uart_byte_t;

	// payload length, 0 to MAX_LEN
	typedef logic [4:0] frame_len_t;

	// payload string, byte 0 in the lowest bits and sent first
	typedef logic [MAX_LEN*8-1:0] frame_str_t;

	// bit position within a character (start, 8 data, stop)
	typedef logic [3:0] bit_cnt_t;

	// clock position within one bit
	typedef logic [3:0] baud_cnt_t;

	// frame delimiter "&", sent twice at each end
	localparam uart_byte_t FRAME_MARK = 8'h26;

endpackage

`default_nettype wire

// ==== hw/uart_frame_top.sv ====
// string framing link over UART, one frame at a time per direction
// receive and transmit paths run independently
// no parity, no flow control, no escaping of "&" in payloads
`timescale 1ns/10ps
`default_nettype none

module uart_frame_top (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::frame_str_t tx_string,
	input  uart_frame_pkg::frame_len_t tx_length,
	input  logic                       tx_req,
	output logic                       tx_busy,
	output logic                       tx_done,
	output uart_frame_pkg::frame_str_t rx_string,
	output uart_frame_pkg::frame_len_t rx_length,
	output logic                       rx_busy,
	output logic                       rx_done,
	output logic                       rx_error,
	input  logic                       uart_rx_port,
	output logic                       uart_tx_port
);

	// frame sender to serializer
	uart_frame_pkg::uart_byte_t  byte_data;
	logic                        byte_req;
	logic                        byte_done;

	// deserializer to frame parser
	uart_frame_pkg::uart_byte_t  rx_byte;
	logic                        rx_vld;

	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx        (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
// 8N1 byte deserializer with mid-bit sampling
// a character whose stop bit reads low is dropped silently
// rx_byte is only valid in the rx_vld cycle
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       rx,
	output uart_frame_pkg::uart_byte_t rx_byte,
	output logic                       rx_vld
);

	logic                        rx_meta;
	logic                        rx_sync;
	logic                        rx_prev;
	logic                        busy;
	uart_frame_pkg::baud_cnt_t   baud_cnt;
	uart_frame_pkg::bit_cnt_t    bit_cnt;
	logic                        bit_mid;
	logic                        bit_end;

	assign bit_mid = (baud_cnt == uart_frame_pkg::baud_cnt_t'(uart_frame_pkg::CLKS_PER_BIT / 2 - 1));
	assign bit_end = (baud_cnt == uart_frame_pkg::baud_cnt_t'(uart_frame_pkg::CLKS_PER_BIT - 1));

	// two-flop synchronizer plus one stage for edge detect
	// idle line is high, so these come out of reset high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			rx_vld   <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			if (!busy) begin
				// falling edge starts a character
				if (rx_prev && !rx_sync) begin
					busy     <= 1'b1;
					baud_cnt <= '0;
					bit_cnt  <= '0;
				end
			end else begin
				if (bit_mid) begin
					if ((bit_cnt == 4'd0) && rx_sync) begin
						// start bit gone by mid-bit, treat as glitch
						busy <= 1'b0;
					end else if (bit_cnt == 4'd9) begin
						busy   <= 1'b0;
						rx_vld <= rx_sync;
					end
				end
				if (bit_end) begin
					baud_cnt <= '0;
					bit_cnt  <= bit_cnt + 4'd1;
				end else begin
					baud_cnt <= baud_cnt + 4'd1;
				end
			end
		end
	end

	// data bits 1..8 shift in from the top, LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (busy && bit_mid && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8)) begin
			rx_byte <= {rx_sync, rx_byte[7:1]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
// 8N1 byte serializer, LSB first
// byte_req is ignored while a character is on the line
// byte_done is high in the last cycle of the stop bit
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::uart_byte_t byte_data,
	input  logic                       byte_req,
	output logic                       tx,
	output logic                       byte_done
);

	logic                        busy;
	uart_frame_pkg::baud_cnt_t   baud_cnt;
	uart_frame_pkg::bit_cnt_t    bit_cnt;
	uart_frame_pkg::uart_byte_t  shreg;
	logic                        bit_end;

	// last clock of the current bit
	assign bit_end = (baud_cnt == uart_frame_pkg::baud_cnt_t'(uart_frame_pkg::CLKS_PER_BIT - 1));

	// bit 9 is the stop bit
	assign byte_done = busy && bit_end && (bit_cnt == 4'd9);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1;
		end else if (!busy) begin
			if (byte_req) begin
				// start bit goes out right away
				busy     <= 1'b1;
				baud_cnt <= '0;
				bit_cnt  <= '0;
				tx       <= 1'b0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
				// after data bit 7 comes the stop bit
				if (bit_cnt == 4'd8) begin
					tx <= 1'b1;
				end else begin
					tx <= shreg[0];
				end
			end
		end else begin
			baud_cnt <= baud_cnt + 4'd1;
		end
	end

	// data shifter, loaded on an accepted request
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req) begin
			shreg <= byte_data;
		end else if (busy && bit_end && (bit_cnt < 4'd8)) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/uart_frame_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/frame_tx.sv
hw/frame_rx.sv
hw/uart_frame_top.sv
dv/uart_frame_tb.sv
